// ==== src/core_types_pkg.sv ====
package core_types_pkg;

  // rob sizing
  localparam int ROB_DEPTH = 32;                 // entries in the reorder buffer
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);  // 5 bits for 32 entries

  // physical register file sizing
  localparam int PREG_COUNT = 64;                // rename pool size
  localparam int PREG_IDX_W = $clog2(PREG_COUNT);

  // architectural register file
  localparam int AREG_COUNT = 32;                // isa visible regs
  localparam int AREG_IDX_W = $clog2(AREG_COUNT);

  // datapath width
  localparam int WORD_W = 64;                    // one result value

  // rob entry index, wraps modulo ROB_DEPTH
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // physical tag written back to the prf
  typedef logic [PREG_IDX_W-1:0] preg_idx_t;

  // destination seen by the map table
  typedef logic [AREG_IDX_W-1:0] areg_idx_t;

  // result payload
  typedef logic [WORD_W-1:0] word_t;

endpackage

// ==== src/cdb_pkg.sv ====
package cdb_pkg;

  import core_types_pkg::*;

  // holding slot occupancy
  typedef enum logic {
    slot_free = 1'b0,  // can take a new result
    slot_held = 1'b1   // waiting for the bus
  } slot_state_e;

  // true when entry_rob sits between rollback_rob and rob_tail inclusive
  // both distances are taken from the rollback entry around the rob ring
  function automatic logic in_squash_window(
    input rob_idx_t entry_rob,     // rob index of the result
    input rob_idx_t rollback_rob,  // first entry to squash
    input rob_idx_t rob_tail       // youngest entry in flight
  );
    int entry_dist;
    int tail_dist;
    // offsets from the rollback point, kept non-negative
    entry_dist = (int'(entry_rob) - int'(rollback_rob) + ROB_DEPTH) % ROB_DEPTH;
    tail_dist  = (int'(rob_tail) - int'(rollback_rob) + ROB_DEPTH) % ROB_DEPTH;
    return (entry_dist <= tail_dist);  // rollback entry itself gives 0
  endfunction

endpackage

// ==== src/fu_result_if.sv ====
interface fu_result_if;

  import core_types_pkg::*;

  logic      valid;  // unit has a finished result
  logic      ready;  // slot can take it this cycle
  preg_idx_t preg;   // destination physical tag
  rob_idx_t  rob;    // owning rob entry
  areg_idx_t areg;   // architectural destination
  word_t     value;  // computed result

  // unit side, driven from the top level ports
  modport producer (
    output valid,
    output preg,
    output rob,
    output areg,
    output value,
    input  ready
  );

  // holding slot side
  modport slot (
    input  valid,
    input  preg,
    input  rob,
    input  areg,
    input  value,
    output ready
  );

endinterface

// ==== src/cdb_slot.sv ====
module cdb_slot (
  input  logic                      clock,
  input  logic                      reset,
  fu_result_if.slot                 result,          // handshake from one unit
  input  logic                      rollback_valid,  // squash request this cycle
  input  core_types_pkg::rob_idx_t  rollback_rob,    // oldest squashed entry
  input  core_types_pkg::rob_idx_t  rob_tail,        // youngest squashed entry
  input  logic                      grant,           // slot owns the bus this cycle
  output logic                      held,            // live result for the arbiter
  output core_types_pkg::preg_idx_t held_preg,
  output core_types_pkg::rob_idx_t  held_rob,
  output core_types_pkg::areg_idx_t held_areg,
  output core_types_pkg::word_t     held_value
);

  import core_types_pkg::*;
  import cdb_pkg::*;

  slot_state_e state_q;  // occupancy
  slot_state_e state_d;

  // stored result fields
  preg_idx_t preg_q;
  rob_idx_t  rob_q;
  areg_idx_t areg_q;
  word_t     value_q;

  logic stored_squash;    // held result killed by rollback
  logic incoming_squash;  // arriving result killed by rollback
  logic slot_ready;       // local copy of the ready we drive
  logic transfer;         // valid and ready both high
  logic store;            // transfer that is kept

  // squash checks against the same window for both sides
  always_comb begin
    stored_squash   = 1'b0;
    incoming_squash = 1'b0;
    if (rollback_valid) begin
      stored_squash   = (state_q == slot_held) &&
                        in_squash_window(rob_q, rollback_rob, rob_tail);
      incoming_squash = in_squash_window(result.rob, rollback_rob, rob_tail);
    end
  end

  // a squashed entry is not offered to the arbiter
  assign held = (state_q == slot_held) && !stored_squash;

  // free now or leaving this cycle through grant or squash
  assign slot_ready   = (state_q == slot_free) || grant || stored_squash;
  assign result.ready = slot_ready;

  assign transfer = result.valid && slot_ready;
  assign store    = transfer && !incoming_squash;  // dropped results still complete handshake

  // next occupancy
  always_comb begin
    state_d = state_q;
    if (store) begin
      state_d = slot_held;  // new result or refill of a granted slot
    end else if (grant || stored_squash) begin
      state_d = slot_free;  // broadcast or killed with nothing to refill
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= slot_free;
    end else begin
      state_q <= state_d;
    end
  end

  // payload loads only on a kept transfer
  always_ff @(posedge clock) begin
    if (store) begin
      preg_q  <= result.preg;
      rob_q   <= result.rob;
      areg_q  <= result.areg;
      value_q <= result.value;
    end
  end

  // fields go straight to the broadcast mux
  assign held_preg  = preg_q;
  assign held_rob   = rob_q;
  assign held_areg  = areg_q;
  assign held_value = value_q;

endmodule

// ==== src/cdb_arbiter.sv ====
module cdb_arbiter #(
  parameter int NUM_FU = 4  // number of holding slots
) (
  input  logic                                   [NUM_FU-1:0] held,        // live slots
  input  core_types_pkg::preg_idx_t [NUM_FU-1:0]              held_preg,   // per slot tag
  input  core_types_pkg::rob_idx_t  [NUM_FU-1:0]              held_rob,    // per slot rob index
  input  core_types_pkg::areg_idx_t [NUM_FU-1:0]              held_areg,   // per slot dest
  input  core_types_pkg::word_t     [NUM_FU-1:0]              held_value,  // per slot value
  output logic                                   [NUM_FU-1:0] grant,       // one-hot or zero
  output logic                                                complete_valid,
  output core_types_pkg::preg_idx_t                           complete_preg,
  output core_types_pkg::rob_idx_t                            complete_rob,
  output core_types_pkg::areg_idx_t                           complete_areg,
  output core_types_pkg::word_t                               complete_value
);

  // lowest index wins
  always_comb begin
    logic found;  // a higher priority slot already won
    found = 1'b0;
    grant = '0;
    for (int i = 0; i < NUM_FU; i++) begin
      if (held[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  // something goes out whenever any slot is live
  assign complete_valid = |held;

  // grant is one-hot so at most one term matches
  always_comb begin
    complete_preg  = '0;  // idle bus reads zero
    complete_rob   = '0;
    complete_areg  = '0;
    complete_value = '0;
    for (int i = 0; i < NUM_FU; i++) begin
      if (grant[i]) begin
        complete_preg  = held_preg[i];
        complete_rob   = held_rob[i];
        complete_areg  = held_areg[i];
        complete_value = held_value[i];
      end
    end
  end

endmodule

// ==== src/cdb_top.sv ====
module cdb_top #(
  parameter int NUM_FU = 4  // functional units feeding the bus
) (
  input  logic                                   clock,
  input  logic                                   reset,

  // functional unit results, one lane per unit
  input  logic                      [NUM_FU-1:0] fu_valid,
  output logic                      [NUM_FU-1:0] fu_ready,
  input  core_types_pkg::preg_idx_t [NUM_FU-1:0] fu_preg,
  input  core_types_pkg::rob_idx_t  [NUM_FU-1:0] fu_rob,
  input  core_types_pkg::areg_idx_t [NUM_FU-1:0] fu_areg,
  input  core_types_pkg::word_t     [NUM_FU-1:0] fu_value,

  // rollback from branch or load recovery
  input  logic                                   rollback_valid,
  input  core_types_pkg::rob_idx_t               rollback_rob,  // first killed entry
  input  core_types_pkg::rob_idx_t               rob_tail,      // last killed entry

  // broadcast to prf, reservation stations, rob and map table
  output logic                                   complete_valid,
  output core_types_pkg::preg_idx_t              complete_preg,
  output core_types_pkg::rob_idx_t               complete_rob,
  output core_types_pkg::areg_idx_t              complete_areg,
  output core_types_pkg::word_t                  complete_value
);

  import core_types_pkg::*;

  // slot to arbiter
  logic      [NUM_FU-1:0] held;        // live result per slot
  logic      [NUM_FU-1:0] grant;       // winner, one-hot
  preg_idx_t [NUM_FU-1:0] held_preg;
  rob_idx_t  [NUM_FU-1:0] held_rob;
  areg_idx_t [NUM_FU-1:0] held_areg;
  word_t     [NUM_FU-1:0] held_value;

  for (genvar i = 0; i < NUM_FU; i++) begin : g_fu

    fu_result_if fu_if ();  // handshake bundle for unit i

    // producer side of the bundle comes from the flat ports
    assign fu_if.valid = fu_valid[i];
    assign fu_if.preg  = fu_preg[i];
    assign fu_if.rob   = fu_rob[i];
    assign fu_if.areg  = fu_areg[i];
    assign fu_if.value = fu_value[i];
    assign fu_ready[i] = fu_if.ready;  // back-pressure to the unit

    cdb_slot slot_i (
      .clock          (clock),
      .reset          (reset),
      .result         (fu_if.slot),
      .rollback_valid (rollback_valid),
      .rollback_rob   (rollback_rob),
      .rob_tail       (rob_tail),
      .grant          (grant[i]),
      .held           (held[i]),
      .held_preg      (held_preg[i]),
      .held_rob       (held_rob[i]),
      .held_areg      (held_areg[i]),
      .held_value     (held_value[i])
    );

  end

  // one result per cycle leaves here
  cdb_arbiter #(
    .NUM_FU (NUM_FU)
  ) arbiter_i (
    .held           (held),
    .held_preg      (held_preg),
    .held_rob       (held_rob),
    .held_areg      (held_areg),
    .held_value     (held_value),
    .grant          (grant),
    .complete_valid (complete_valid),
    .complete_preg  (complete_preg),
    .complete_rob   (complete_rob),
    .complete_areg  (complete_areg),
    .complete_value (complete_value)
  );

endmodule

// ==== dv/cdb_tb_table.svh ====
`ifndef CDB_TB_TABLE_SVH
`define CDB_TB_TABLE_SVH

  // each row gives name, fu_valid[3:0], rob of units 3 2 1 0, rollback_valid, rollback_rob,
  // rob_tail, expected complete_valid, expected complete_rob and expected fu_ready[3:0]
  // preg, areg and value of every lane come from the payload tables indexed by rob
  task automatic load_table();
    // idle bus straight out of reset
    put_row("reset_idle",        4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);

    // one result on unit 2 broadcast a cycle later
    put_row("single_u2_in",      4'b0100,  0,  5,  0,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("single_u2_out",     4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  5, 4'b1111);
    put_row("single_u2_done",    4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);

    // units 0 1 3 together drained lowest index first
    put_row("three_in",          4'b1011,  3,  0,  2,  1, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("three_out_u0",      4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  1, 4'b0101);
    put_row("three_out_u1",      4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  2, 4'b0111);
    put_row("three_out_u3",      4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  3, 4'b1111);

    // new result taken in the grant cycle of the same slot
    put_row("refill_load",       4'b0010,  0,  0,  8,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("refill_granted",    4'b0010,  0,  0,  9,  0, 1'b0,  0,  0, 1'b1,  8, 4'b1111);
    put_row("refill_out",        4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  9, 4'b1111);

    // unit 1 blocked behind unit 0 keeps valid until ready
    put_row("stall_load",        4'b0011,  0,  0, 17, 16, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("stall_u1_blocked",  4'b0011,  0,  0, 19, 18, 1'b0,  0,  0, 1'b1, 16, 4'b1101);
    put_row("stall_u1_waits",    4'b0010,  0,  0, 19,  0, 1'b0,  0,  0, 1'b1, 18, 4'b1101);
    put_row("stall_u1_accepted", 4'b0010,  0,  0, 19,  0, 1'b0,  0,  0, 1'b1, 17, 4'b1111);
    put_row("stall_drain",       4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1, 19, 4'b1111);

    // window 10..14 kills 10 and 13 and drops arriving 12 while rob 7 survives
    put_row("rb_load",           4'b1011,  7,  0, 13, 10, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("rb_squash",         4'b0100,  0, 12,  0,  0, 1'b1, 10, 14, 1'b1,  7, 4'b1111);
    put_row("rb_after",          4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);

    // window 30..1 wraps past 31 and kills 31 and 0 and drops arriving 30
    put_row("wrap_load",         4'b1111,  0,  2, 31, 29, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
    put_row("wrap_squash",       4'b0010,  0,  0, 30,  0, 1'b1, 30,  1, 1'b1, 29, 4'b1011);
    put_row("wrap_survivor",     4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b1,  2, 4'b1111);
    put_row("wrap_idle",         4'b0000,  0,  0,  0,  0, 1'b0,  0,  0, 1'b0,  0, 4'b1111);
  endtask

`endif

// ==== dv/cdb_tb.sv ====
module cdb_tb;

  import core_types_pkg::*;

  localparam int NUM_FU        = 4;
  localparam int CLOCK_HALF    = 50;  // period 100
  localparam int RESET_CYCLES  = 5;
  localparam int DRIVE_DELAY   = 10;  // inputs move shortly after the edge
  localparam int CHECK_DELAY   = 80;  // outputs sampled just before the next edge
  localparam int TIMEOUT_SLACK = 20;

  logic                   clock;
  logic                   reset;
  logic      [NUM_FU-1:0] fu_valid;
  logic      [NUM_FU-1:0] fu_ready;
  preg_idx_t [NUM_FU-1:0] fu_preg;
  rob_idx_t  [NUM_FU-1:0] fu_rob;
  areg_idx_t [NUM_FU-1:0] fu_areg;
  word_t     [NUM_FU-1:0] fu_value;
  logic                   rollback_valid;
  rob_idx_t               rollback_rob;
  rob_idx_t               rob_tail;
  logic                   complete_valid;
  preg_idx_t              complete_preg;
  rob_idx_t               complete_rob;
  areg_idx_t              complete_areg;
  word_t                  complete_value;

  // stimulus and expected values, one entry per cycle
  string                  row_name      [$];
  logic      [NUM_FU-1:0] row_valid     [$];
  rob_idx_t  [NUM_FU-1:0] row_rob       [$];
  logic                   row_rb        [$];
  rob_idx_t               row_rb_rob    [$];
  rob_idx_t               row_tail      [$];
  logic                   row_exp_valid [$];
  rob_idx_t               row_exp_rob   [$];
  logic      [NUM_FU-1:0] row_exp_ready [$];

  // payload per rob index so results stay traceable
  preg_idx_t preg_of  [ROB_DEPTH];
  areg_idx_t areg_of  [ROB_DEPTH];
  word_t     value_of [ROB_DEPTH];

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;
  int     timeout_limit;

  cdb_top #(
    .NUM_FU (NUM_FU)
  ) dut_i (
    .clock          (clock),
    .reset          (reset),
    .fu_valid       (fu_valid),
    .fu_ready       (fu_ready),
    .fu_preg        (fu_preg),
    .fu_rob         (fu_rob),
    .fu_areg        (fu_areg),
    .fu_value       (fu_value),
    .rollback_valid (rollback_valid),
    .rollback_rob   (rollback_rob),
    .rob_tail       (rob_tail),
    .complete_valid (complete_valid),
    .complete_preg  (complete_preg),
    .complete_rob   (complete_rob),
    .complete_areg  (complete_areg),
    .complete_value (complete_value)
  );

  always #CLOCK_HALF clock = ~clock;

  // int table entry down to a rob index
  function automatic rob_idx_t rob_of(input int r);
    return r[ROB_IDX_W-1:0];
  endfunction

  task automatic put_row(input string name, input logic [NUM_FU-1:0] valid,
                         input int r3, input int r2, input int r1, input int r0,
                         input logic rb, input int rb_rob, input int tail,
                         input logic exp_valid, input int exp_rob,
                         input logic [NUM_FU-1:0] exp_ready);
    row_name.push_back(name);
    row_valid.push_back(valid);
    row_rob.push_back({rob_of(r3), rob_of(r2), rob_of(r1), rob_of(r0)});
    row_rb.push_back(rb);
    row_rb_rob.push_back(rob_of(rb_rob));
    row_tail.push_back(rob_of(tail));
    row_exp_valid.push_back(exp_valid);
    row_exp_rob.push_back(rob_of(exp_rob));
    row_exp_ready.push_back(exp_ready);
  endtask

  `include "cdb_tb_table.svh"

  task automatic build_payload();
    logic [31:0] rand_lo;
    logic [31:0] rand_hi;
    for (int r = 0; r < ROB_DEPTH; r++) begin
      rand_lo     = $random(seed);
      rand_hi     = $random(seed);
      preg_of[r]  = rand_lo[PREG_IDX_W-1:0];
      areg_of[r]  = rand_hi[AREG_IDX_W-1:0];
      rand_lo     = $random(seed);
      rand_hi     = $random(seed);
      value_of[r] = {rand_hi, rand_lo};
    end
  endtask

  task automatic check_value(input string test_name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
    end
  endtask

  task automatic drive_row(input int i);
    rob_idx_t rob;
    fu_valid = row_valid[i];
    for (int u = 0; u < NUM_FU; u++) begin
      rob         = row_rob[i][u];
      fu_rob[u]   = rob;
      fu_preg[u]  = preg_of[rob];  // fields tied to the rob index
      fu_areg[u]  = areg_of[rob];
      fu_value[u] = value_of[rob];
    end
    rollback_valid = row_rb[i];
    rollback_rob   = row_rb_rob[i];
    rob_tail       = row_tail[i];
  endtask

  task automatic check_row(input int i);
    rob_idx_t  exp_rob;
    preg_idx_t exp_preg;
    areg_idx_t exp_areg;
    word_t     exp_value;
    exp_rob   = row_exp_rob[i];
    exp_preg  = '0;  // idle bus reads zero
    exp_areg  = '0;
    exp_value = '0;
    if (row_exp_valid[i]) begin
      exp_preg  = preg_of[exp_rob];
      exp_areg  = areg_of[exp_rob];
      exp_value = value_of[exp_rob];
    end
    check_value(row_name[i], "complete_valid", 64'(row_exp_valid[i]), 64'(complete_valid));
    check_value(row_name[i], "complete_rob", 64'(exp_rob), 64'(complete_rob));
    check_value(row_name[i], "complete_preg", 64'(exp_preg), 64'(complete_preg));
    check_value(row_name[i], "complete_areg", 64'(exp_areg), 64'(complete_areg));
    check_value(row_name[i], "complete_value", exp_value, complete_value);
    check_value(row_name[i], "fu_ready", 64'(row_exp_ready[i]), 64'(fu_ready));
  endtask

  // run limit from table length
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", timeout_limit);
      $display("errors: %0d, checks: %0d", error_count, check_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed           = 32'h760a_910d;
    clock          = 1'b0;
    reset          = 1'b1;
    fu_valid       = '0;
    fu_preg        = '0;
    fu_rob         = '0;
    fu_areg        = '0;
    fu_value       = '0;
    rollback_valid = 1'b0;
    rollback_rob   = '0;
    rob_tail       = '0;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    build_payload();
    load_table();
    timeout_limit = row_name.size() + RESET_CYCLES + TIMEOUT_SLACK;

    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;

    // one row per clock cycle
    for (int i = 0; i < row_name.size(); i++) begin
      drive_row(i);
      #CHECK_DELAY;
      check_row(i);
      @(posedge clock);
      #DRIVE_DELAY;
    end

    $display("errors: %0d, checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+dv
src/core_types_pkg.sv
src/cdb_pkg.sv
src/fu_result_if.sv
src/cdb_slot.sv
src/cdb_arbiter.sv
src/cdb_top.sv
dv/cdb_tb.sv
